/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dbus
LINT_TOP  ?= dbus_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := *** PASSED ***

RTL_SRCS  := $(shell grep '^hdl/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(LINT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flash.hex */
// one 32-bit flash word per line, word address 0 to 15
3c1d1fd0
27bdfff0
afbf000c
0c780010
00000000
8fbf000c
03e00008
27bd0010
a5a55a5a
0badf00d
12345678
89abcdef
deadbeef
00ff00ff
f0e1d2c3
7fffffff

/* hdl/dbus.sv */
`timescale 1ns/1ps

module dbus import dbus_pkg::*; (
    input  bus_req_t    req_i,

    output bus_req_t    ram_req_o,
    output bus_req_t    flash_req_o,
    output bus_req_t    io_req_o,

    input  logic [31:0] ram_rdata_i,
    input  logic [31:0] flash_rdata_i,
    input  logic [31:0] io_rdata_i,
    input  logic        ram_stall_i,
    input  logic        flash_stall_i,

    output logic [31:0] rdata_o,
    output logic        stall_o
);

    logic ram_sel;
    logic flash_sel;
    logic io_sel;

    // **************************************************
    // window decode
    // **************************************************
    // ram wins over flash and flash over i/o.
    always_comb begin
        ram_sel   = 1'b0;
        flash_sel = 1'b0;
        io_sel    = 1'b0;
        if (req_i.address.mem.region == REGION_RAM) begin
            ram_sel = 1'b1;
        end else if (req_i.address.mem.region == REGION_FLASH) begin
            flash_sel = 1'b1;
        end else if (req_i.address.io.page == PAGE_GPIO ||
                     req_i.address.io.page == PAGE_TICKER) begin
            io_sel = 1'b1; // io_regs splits both pages.
        end
    end

    // **************************************************
    // requests to slaves
    // **************************************************
    always_comb begin
        ram_req_o         = req_i;
        ram_req_o.read    = req_i.read & ram_sel;
        ram_req_o.write   = req_i.write & ram_sel;

        flash_req_o       = req_i;
        flash_req_o.read  = req_i.read & flash_sel;
        flash_req_o.write = req_i.write & flash_sel;

        io_req_o          = req_i;
        io_req_o.read     = req_i.read & io_sel;
        io_req_o.write    = req_i.write & io_sel;
    end

    // **************************************************
    // response back to master
    // **************************************************
    always_comb begin
        rdata_o = 32'h0; // unmapped reads zero.
        stall_o = 1'b0;
        if (ram_sel) begin
            rdata_o = ram_rdata_i;
            stall_o = ram_stall_i;
        end else if (flash_sel) begin
            rdata_o = flash_rdata_i;
            stall_o = flash_stall_i;
        end else if (io_sel) begin
            rdata_o = io_rdata_i; // never stalls.
        end
    end

endmodule

/* hdl/dbus_pkg.sv */
package dbus_pkg;

    // **************************************************
    // address map
    // **************************************************
    localparam logic [7:0]  REGION_RAM   = 8'h00;
    localparam logic [7:0]  REGION_FLASH = 8'h1e;
    localparam logic [23:0] PAGE_GPIO    = 24'h1fd004;
    localparam logic [23:0] PAGE_TICKER  = 24'h1fd005;

    localparam logic [7:0]  REG_GPIO_OUT = 8'h00;
    localparam logic [7:0]  REG_GPIO_IN  = 8'h04;

    // memory sizes and flash timing.
    localparam int RAM_WORDS   = 1024;
    localparam int FLASH_WORDS = 16;
    localparam int FLASH_WAIT  = 3;
    localparam int RAM_AW      = $clog2(RAM_WORDS);
    localparam int FLASH_AW    = $clog2(FLASH_WORDS);
    localparam int FLASH_CNT_W = $clog2(FLASH_WAIT + 1);

    // **************************************************
    // bus types
    // **************************************************
    typedef struct packed {
        logic [7:0]  region;
        logic [23:0] offset;
    } mem_addr_t;

    typedef struct packed {
        logic [23:0] page;
        logic [7:0]  index;
    } io_addr_t;

    // one word seen by memory or by i/o decode.
    typedef union packed {
        mem_addr_t mem;
        io_addr_t  io;
    } bus_addr_u;

    typedef struct packed {
        bus_addr_u   address;
        logic [3:0]  byte_en;
        logic        read;
        logic        write;
        logic [31:0] wdata;
    } bus_req_t;

endpackage

/* hdl/dbus_top.sv */
`timescale 1ns/1ps

module dbus_top import dbus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,

    input  bus_req_t    master_req_i,
    output logic [31:0] master_rdata_o,
    output logic        master_stall_o,

    input  logic [31:0] gpio_pins_i,
    output logic [31:0] gpio_pins_o
);

    bus_req_t    ram_req;
    bus_req_t    flash_req;
    bus_req_t    io_req;
    logic [31:0] ram_rdata;
    logic [31:0] flash_rdata;
    logic [31:0] io_rdata;
    logic        ram_stall;
    logic        flash_stall;

    // **************************************************
    // decoder
    // **************************************************
    dbus i_dbus (
        .req_i         (master_req_i),
        .ram_req_o     (ram_req),
        .flash_req_o   (flash_req),
        .io_req_o      (io_req),
        .ram_rdata_i   (ram_rdata),
        .flash_rdata_i (flash_rdata),
        .io_rdata_i    (io_rdata),
        .ram_stall_i   (ram_stall),
        .flash_stall_i (flash_stall),
        .rdata_o       (master_rdata_o),
        .stall_o       (master_stall_o)
    );

    // **************************************************
    // slaves
    // **************************************************
    ram_ctrl i_ram_ctrl (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (ram_req),
        .rdata_o (ram_rdata),
        .stall_o (ram_stall)
    );

    flash_rom i_flash_rom (
        .clk     (clk),
        .rst_i   (rst_i),
        .req_i   (flash_req),
        .rdata_o (flash_rdata),
        .stall_o (flash_stall)
    );

    io_regs i_io_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       (io_req),
        .gpio_pins_i (gpio_pins_i),
        .gpio_pins_o (gpio_pins_o),
        .rdata_o     (io_rdata)
    );

endmodule

/* hdl/flash_rom.sv */
`timescale 1ns/1ps

module flash_rom import dbus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  bus_req_t    req_i,
    output logic [31:0] rdata_o,
    output logic        stall_o
);

    logic [31:0]            rom [FLASH_WORDS];
    logic [FLASH_AW-1:0]    idx;
    logic [FLASH_CNT_W-1:0] wait_cnt;
    logic                   strobe;

    // **************************************************
    // contents
    // **************************************************
    initial begin
        $readmemh("flash.hex", rom);
    end

    assign idx    = req_i.address.mem.offset[FLASH_AW+1:2];
    assign strobe = req_i.read | req_i.write;

    // stall until the counter reaches the wait count.
    assign stall_o = strobe && (wait_cnt != FLASH_CNT_W'(FLASH_WAIT));
    assign rdata_o = rom[idx];

    // **************************************************
    // wait counter
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wait_cnt <= '0;
        end else if (stall_o) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0; // access done or bus idle.
        end
    end

    // writes take the wait and leave contents alone.

endmodule

/* hdl/io_regs.sv */
`timescale 1ns/1ps

module io_regs import dbus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  bus_req_t    req_i,
    input  logic [31:0] gpio_pins_i,
    output logic [31:0] gpio_pins_o,
    output logic [31:0] rdata_o
);

    logic        gpio_page;
    logic        ticker_page;
    logic [31:0] gpio_meta;
    logic [31:0] gpio_sync;
    logic [31:0] ticker;

    assign gpio_page   = req_i.address.io.page == PAGE_GPIO;
    assign ticker_page = req_i.address.io.page == PAGE_TICKER;

    // **************************************************
    // gpio
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            gpio_pins_o <= 32'h0;
        end else if (req_i.write && gpio_page &&
                     req_i.address.io.index == REG_GPIO_OUT) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byte_en[b]) begin
                    gpio_pins_o[8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    // two flop synchronizer on the pins.
    always_ff @(posedge clk) begin
        gpio_meta <= gpio_pins_i;
        gpio_sync <= gpio_meta;
    end

    // **************************************************
    // ticker
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ticker <= 32'h0;
        end else if (req_i.write && ticker_page) begin
            ticker <= req_i.wdata; // full word load.
        end else begin
            ticker <= ticker + 32'd1;
        end
    end

    // read mux.
    always_comb begin
        rdata_o = 32'h0;
        if (gpio_page) begin
            if (req_i.address.io.index == REG_GPIO_OUT) rdata_o = gpio_pins_o;
            else if (req_i.address.io.index == REG_GPIO_IN) rdata_o = gpio_sync;
        end else if (ticker_page) begin
            rdata_o = ticker;
        end
    end

endmodule

/* hdl/ram_ctrl.sv */
`timescale 1ns/1ps

module ram_ctrl import dbus_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  bus_req_t    req_i,
    output logic [31:0] rdata_o,
    output logic        stall_o
);

    logic [31:0]       mem [RAM_WORDS];
    logic [RAM_AW-1:0] idx;
    logic              strobe;
    logic              done;

    // word index wraps over depth.
    assign idx    = req_i.address.mem.offset[RAM_AW+1:2];
    assign strobe = req_i.read | req_i.write;

    // one wait state per access.
    assign stall_o = strobe & ~done;

    // **************************************************
    // wait state flag
    // **************************************************
    always_ff @(posedge clk) begin
        if (rst_i) begin
            done <= 1'b0;
        end else begin
            done <= stall_o; // high for the cycle after a wait.
        end
    end

    // **************************************************
    // storage
    // **************************************************
    always_ff @(posedge clk) begin
        rdata_o <= mem[idx]; // registered read.
        if (req_i.write && done) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.byte_en[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* list.f */
hdl/dbus_pkg.sv
hdl/dbus.sv
hdl/ram_ctrl.sv
hdl/flash_rom.sv
hdl/io_regs.sv
hdl/dbus_top.sv
tests/dbus_props.sv
tests/tb_dbus.sv

/* tests/dbus_props.sv */
`timescale 1ns/1ps

module dbus_props import dbus_pkg::*; (
    input logic     clk,
    input logic     rst_i,
    input bus_req_t req_i,
    input logic     stall_i,
    input bus_req_t ram_req_i,
    input bus_req_t flash_req_i,
    input bus_req_t io_req_i,
    input logic     ram_stall_i,
    input logic     flash_stall_i
);

    logic strobe;
    logic [2:0] slave_strobes;

    assign strobe        = req_i.read | req_i.write;
    assign slave_strobes = {ram_req_i.read | ram_req_i.write,
                            flash_req_i.read | flash_req_i.write,
                            io_req_i.read | io_req_i.write};

    // **************************************************
    // stall and strobe rules
    // **************************************************
    stall_needs_strobe: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |-> strobe)
        else $error("master stall high with no strobe");

    one_slave: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(slave_strobes))
        else $error("two slave strobes high together");

    // master holds while stalled.
    hold_req: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable(req_i))
        else $error("request changed during stall");

    ram_one_wait: assert property (@(posedge clk) disable iff (rst_i)
        ram_stall_i |=> !ram_stall_i)
        else $error("ram stalled more than one cycle");

    flash_wait: assert property (@(posedge clk) disable iff (rst_i)
        $rose(flash_stall_i) |-> ##FLASH_WAIT !flash_stall_i)
        else $error("flash stall longer than wait count");

endmodule

bind dbus_top dbus_props i_dbus_props (
    .clk           (clk),
    .rst_i         (rst_i),
    .req_i         (master_req_i),
    .stall_i       (master_stall_o),
    .ram_req_i     (ram_req),
    .flash_req_i   (flash_req),
    .io_req_i      (io_req),
    .ram_stall_i   (ram_stall),
    .flash_stall_i (flash_stall)
);

/* tests/tb_dbus.sv */
`timescale 1ns/1ps

module tb_dbus import dbus_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int QTR          = CLK_PERIOD / 4;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CYCLES   = 4000; // tests need about 800 cycles.

    logic        clk;
    logic        rst;
    bus_req_t    master_req;
    logic [31:0] master_rdata;
    logic        master_stall;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;

    // reference model.
    logic [31:0] ram_ref [RAM_WORDS];
    logic [31:0] flash_ref [FLASH_WORDS];
    logic [31:0] gpio_ref;
    int          errors;
    int          cycle;

    dbus_top i_dbus_top (
        .clk            (clk),
        .rst_i          (rst),
        .master_req_i   (master_req),
        .master_rdata_o (master_rdata),
        .master_stall_o (master_stall),
        .gpio_pins_i    (gpio_in),
        .gpio_pins_o    (gpio_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: no verdict after %0d cycles", cycle);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] ram_addr(input int unsigned idx);
        return {REGION_RAM, 22'(idx), 2'b00};
    endfunction

    function automatic logic [31:0] flash_addr(input int unsigned idx);
        return {REGION_FLASH, 22'(idx), 2'b00};
    endfunction

    function automatic logic [31:0] io_addr(input logic [23:0] page, input logic [7:0] index);
        return {page, index};
    endfunction

    // **************************************************
    // bus access
    // **************************************************
    // sampled a quarter period after the falling edge.
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int n_stall, output int done_cycle);
        @(negedge clk);
        master_req.address = addr;
        master_req.byte_en = be;
        master_req.read    = ~wr;
        master_req.write   = wr;
        master_req.wdata   = wdata;
        n_stall = 0;
        #(QTR);
        while (master_stall) begin
            n_stall++;
            @(negedge clk);
            #(QTR);
        end
        rdata      = master_rdata;
        done_cycle = cycle; // completing edge is the next one.
        @(negedge clk);
        master_req.read  = 1'b0;
        master_req.write = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] be,
                              input logic [31:0] data, input int exp_stalls);
        logic [31:0] dummy;
        int          n;
        int          c;
        bus_access(1'b1, addr, be, data, dummy, n, c);
        if (n != exp_stalls) begin
            errors++;
            $display("error at %0t: write %h stalled %0d, expected %0d",
                     $time, addr, n, exp_stalls);
        end
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [31:0] exp,
                             input int exp_stalls);
        logic [31:0] got;
        int          n;
        int          c;
        bus_access(1'b0, addr, 4'hf, 32'h0, got, n, c);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: read %h gave %h, expected %h", $time, addr, got, exp);
        end
        if (n != exp_stalls) begin
            errors++;
            $display("error at %0t: read %h stalled %0d, expected %0d",
                     $time, addr, n, exp_stalls);
        end
    endtask

    // **************************************************
    // tests
    // **************************************************
    task automatic test_ram();
        int unsigned idx_q [$];
        int unsigned idx;
        logic [31:0] data;
        logic [3:0]  be;
        for (int i = 0; i < 64; i++) begin
            idx  = $urandom_range(RAM_WORDS - 1);
            data = $urandom;
            write_word(ram_addr(idx), 4'hf, data, 1); // defined word first.
            ram_ref[idx] = data;
            data = $urandom;
            be   = 4'($urandom);
            write_word(ram_addr(idx), be, data, 1);
            ram_ref[idx] = merge_bytes(ram_ref[idx], data, be);
            idx_q.push_back(idx);
        end
        foreach (idx_q[i]) read_word(ram_addr(idx_q[i]), ram_ref[idx_q[i]], 1);
    endtask

    task automatic test_flash();
        for (int i = 0; i < FLASH_WORDS; i++) begin
            read_word(flash_addr(i), flash_ref[i], FLASH_WAIT);
        end
        write_word(flash_addr(5), 4'hf, ~flash_ref[5], FLASH_WAIT);
        read_word(flash_addr(5), flash_ref[5], FLASH_WAIT);
    endtask

    task automatic test_gpio();
        logic [31:0] data;
        data = $urandom;
        write_word(io_addr(PAGE_GPIO, REG_GPIO_OUT), 4'hf, data, 0);
        gpio_ref = data;
        data = $urandom;
        write_word(io_addr(PAGE_GPIO, REG_GPIO_OUT), 4'b0101, data, 0);
        gpio_ref = merge_bytes(gpio_ref, data, 4'b0101);
        if (gpio_out !== gpio_ref) begin
            errors++;
            $display("error at %0t: gpio pins %h, expected %h", $time, gpio_out, gpio_ref);
        end
        read_word(io_addr(PAGE_GPIO, REG_GPIO_OUT), gpio_ref, 0);
        data    = $urandom;
        gpio_in = data;
        repeat (2) @(negedge clk); // synchronizer depth.
        read_word(io_addr(PAGE_GPIO, REG_GPIO_IN), data, 0);
    endtask

    task automatic test_ticker();
        logic [31:0] data;
        logic [31:0] got;
        int          n;
        int          c_w;
        int          c_r;
        for (int i = 0; i < 4; i++) begin
            data = $urandom;
            bus_access(1'b1, io_addr(PAGE_TICKER, 8'h00), 4'h1, data, got, n, c_w);
            repeat ($urandom_range(9, 2)) @(negedge clk);
            bus_access(1'b0, io_addr(PAGE_TICKER, 8'h00), 4'hf, 32'h0, got, n, c_r);
            // loaded at the write edge, then one step per edge before the read edge.
            data = data + 32'(c_r - c_w - 1);
            if (got !== data || n != 0) begin
                errors++;
                $display("error at %0t: ticker %h stall %0d, expected %h", $time, got, n, data);
            end
        end
    endtask

    task automatic test_decode();
        logic [31:0] data;
        data = $urandom;
        write_word(ram_addr(3), 4'hf, data, 1);
        ram_ref[3] = data;
        read_word(32'h4000_0000, 32'h0, 0);
        read_word(io_addr(24'h1fd006, 8'h00), 32'h0, 0);
        read_word(io_addr(PAGE_GPIO, 8'h08), 32'h0, 0);
        write_word({8'h40, 22'(3), 2'b00}, 4'hf, ~data, 0);
        write_word(io_addr(24'h1fd006, REG_GPIO_OUT), 4'hf, ~data, 0);
        write_word(io_addr(PAGE_GPIO, 8'h08), 4'hf, ~data, 0);
        read_word(ram_addr(3), ram_ref[3], 1);
        read_word(flash_addr(3), flash_ref[3], FLASH_WAIT);
        read_word(io_addr(PAGE_GPIO, REG_GPIO_OUT), gpio_ref, 0);
        // offsets past the depth wrap.
        data = $urandom;
        write_word(ram_addr(RAM_WORDS + 7), 4'hf, data, 1);
        ram_ref[(RAM_WORDS + 7) % RAM_WORDS] = data;
        read_word(ram_addr(7), ram_ref[7], 1);
    endtask

    task automatic test_reset();
        logic [31:0] got;
        int          n;
        int          c_rel;
        int          c_r;
        @(negedge clk);
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        #(QTR);
        c_rel    = cycle;
        gpio_ref = 32'h0;
        if (gpio_out !== 32'h0 || master_stall !== 1'b0) begin
            errors++;
            $display("error at %0t: after reset pins %h stall %b", $time, gpio_out, master_stall);
        end
        bus_access(1'b0, io_addr(PAGE_TICKER, 8'h00), 4'hf, 32'h0, got, n, c_r);
        if (got !== 32'(c_r - c_rel)) begin
            errors++;
            $display("error at %0t: ticker after reset %h, expected %h",
                     $time, got, 32'(c_r - c_rel));
        end
        read_word(ram_addr(3), ram_ref[3], 1); // ram keeps its contents.
    endtask

    initial begin
        void'($urandom(32'hcbc5));
        $readmemh("flash.hex", flash_ref);
        clk        = 1'b0;
        rst        = 1'b1;
        master_req = '0;
        gpio_in    = 32'h0;
        gpio_ref   = 32'h0;
        errors     = 0;
        cycle      = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        test_ram();
        test_flash();
        test_gpio();
        test_ticker();
        test_decode();
        test_reset();
        repeat (2) @(negedge clk);
        $display("run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
